// ==== rtl/i2c_cfg.svh ====
// ==========================================================
// Build-time configuration of the multi-channel I2C controller
// Divider assumes a 25 MHz clock for roughly 400 kHz SCL
// All buses talk to the same 7-bit target address
// ==========================================================
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// Number of independent buses, one master each
`define I2C_NUM_CHAN    2

// Clock cycles per quarter SCL period
`define I2C_QUARTER_DIV 15

// 7-bit target address
`define I2C_DEV_ADDR    7'h48

`endif

// ==== rtl/i2c_pkg.sv ====
// ==========================================================
// Shared command, response and FSM types
// Channel index is at least one bit wide
// ==========================================================
`include "i2c_cfg.svh"

package i2c_pkg;

    // One bit minimum so a single-bus build still has a field
    localparam int chan_w = (`I2C_NUM_CHAN > 1) ? $clog2(`I2C_NUM_CHAN) : 1;

    typedef logic [chan_w-1:0] chan_t;

    typedef struct packed {
        chan_t      chan;
        logic       rw;       // 1 = read
        logic [7:0] wdata;
    } i2c_cmd_t;

    typedef struct packed {
        chan_t      chan;
        logic       rw;
        logic       nack;     // Address not acknowledged
        logic [7:0] rdata;    // Zero for writes
    } i2c_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        START_COND,
        SEND_ADDR,
        WRITE_BYTE,
        READ_BYTE,
        STOP_COND
    } i2c_state_e;

endpackage

// ==== rtl/i2c_cmd_dispatch.sv ====
// ==========================================================
// Routes a loaded command to its channel master
// A busy or out-of-range channel gets a reject pulse
// ==========================================================
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_cmd_dispatch (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  i2c_pkg::i2c_cmd_t        cmd,
    input  logic [`I2C_NUM_CHAN-1:0] chan_busy,
    output logic [`I2C_NUM_CHAN-1:0] start,
    output logic                     start_rw,
    output logic [7:0]               start_wdata,
    output logic                     reject
);

    logic [`I2C_NUM_CHAN-1:0] occupied;
    logic                     in_range;
    logic                     chan_free;

    // Master raises busy one cycle after start, so cover that gap
    assign occupied  = chan_busy | start;
    assign in_range  = (int'(cmd.chan) < `I2C_NUM_CHAN);
    assign chan_free = in_range && !occupied[cmd.chan];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start  <= '0;
            reject <= 1'b0;
        end else begin
            start  <= '0;
            reject <= load && !chan_free;
            if (load && chan_free) begin
                start[cmd.chan] <= 1'b1;     // One-hot pulse
            end
        end
    end

    // Shared start data, valid alongside the start pulse
    always_ff @(posedge clk) begin
        if (load) begin
            start_rw    <= cmd.rw;
            start_wdata <= cmd.wdata;
        end
    end

endmodule

// ==== rtl/i2c_byte_master.sv ====
// ==========================================================
// Single-byte I2C master, open drain, one per bus
// No repeated START, clock stretching or arbitration
// SDA pin trails the FSM by one clock so SDA edges follow SCL
// STOP setup time is therefore one clock
// ==========================================================
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_byte_master #(
    parameter int chan_id = 0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              start_rw,
    input  logic [7:0]        start_wdata,
    output logic              busy,
    output logic              done,
    output i2c_pkg::i2c_rsp_t rsp,
    inout  wire               sda,
    inout  wire               scl
);

    localparam int               cnt_w    = $clog2(`I2C_QUARTER_DIV + 1);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`I2C_QUARTER_DIV - 1);

    i2c_pkg::i2c_state_e state;
    logic [1:0]          phase;      // Quarter within the current bit
    logic [2:0]          bit_cnt;
    logic [7:0]          shift_reg;  // Outgoing bits, MSB first
    logic [7:0]          wdata_q;
    logic                rw_q;
    logic                nack_q;
    logic [7:0]          rdata_q;
    logic                sda_oe;     // 1 = pull low
    logic                sda_oe_q;
    logic                scl_oe;
    logic [cnt_w-1:0]    div_cnt;
    logic                tick;

    // ======================================================
    // Quarter-period tick
    // ======================================================
    assign busy = (state != i2c_pkg::IDLE);
    assign tick = busy && (div_cnt == cnt_last);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (!busy || tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ======================================================
    // Open-drain pins
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sda_oe_q <= 1'b0;
        end else begin
            sda_oe_q <= sda_oe;
        end
    end

    assign sda = sda_oe_q ? 1'b0 : 1'bz;
    assign scl = scl_oe   ? 1'b0 : 1'bz;

    // ======================================================
    // Bit sequencer
    // ======================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= i2c_pkg::IDLE;
            phase     <= 2'd0;
            bit_cnt   <= 3'd0;
            shift_reg <= 8'd0;
            wdata_q   <= 8'd0;
            rw_q      <= 1'b0;
            nack_q    <= 1'b0;
            rdata_q   <= 8'd0;
            sda_oe    <= 1'b0;
            scl_oe    <= 1'b0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                i2c_pkg::IDLE: begin
                    sda_oe <= 1'b0;
                    scl_oe <= 1'b0;
                    phase  <= 2'd0;
                    if (start) begin
                        shift_reg <= {`I2C_DEV_ADDR, start_rw};
                        wdata_q   <= start_wdata;
                        rw_q      <= start_rw;
                        nack_q    <= 1'b0;
                        rdata_q   <= 8'd0;
                        state     <= i2c_pkg::START_COND;
                    end
                end

                i2c_pkg::START_COND: begin
                    if (tick) begin
                        if (phase == 2'd0) begin
                            sda_oe <= 1'b1;              // SDA falls, SCL high
                            phase  <= 2'd1;
                        end else begin
                            scl_oe  <= 1'b1;
                            bit_cnt <= 3'd7;
                            phase   <= 2'd0;
                            state   <= i2c_pkg::SEND_ADDR;
                        end
                    end
                end

                i2c_pkg::SEND_ADDR, i2c_pkg::WRITE_BYTE: begin
                    if (tick) begin
                        case (phase)
                            2'd0: begin
                                scl_oe <= 1'b1;
                                sda_oe <= ~shift_reg[7];
                                phase  <= 2'd1;
                            end
                            2'd1: begin
                                scl_oe <= 1'b0;          // Data valid
                                phase  <= 2'd2;
                            end
                            2'd2: begin
                                scl_oe    <= 1'b1;
                                shift_reg <= {shift_reg[6:0], 1'b0};
                                if (bit_cnt == 3'd0) begin
                                    sda_oe <= 1'b0;      // Hand SDA to target for ACK
                                    phase  <= 2'd3;
                                end else begin
                                    bit_cnt <= bit_cnt - 1'b1;
                                    phase   <= 2'd0;
                                end
                            end
                            default: begin
                                scl_oe  <= 1'b0;
                                bit_cnt <= 3'd7;
                                phase   <= 2'd0;
                                if (state == i2c_pkg::WRITE_BYTE) begin
                                    state <= i2c_pkg::STOP_COND;   // Data ACK ignored
                                end else begin
                                    nack_q <= sda;
                                    if (sda) begin
                                        state <= i2c_pkg::STOP_COND;
                                    end else if (rw_q) begin
                                        state <= i2c_pkg::READ_BYTE;
                                    end else begin
                                        shift_reg <= wdata_q;
                                        state     <= i2c_pkg::WRITE_BYTE;
                                    end
                                end
                            end
                        endcase
                    end
                end

                i2c_pkg::READ_BYTE: begin
                    if (tick) begin
                        case (phase)
                            2'd0: begin
                                scl_oe <= 1'b1;
                                sda_oe <= 1'b0;
                                phase  <= 2'd1;
                            end
                            2'd1: begin
                                scl_oe <= 1'b0;
                                phase  <= 2'd2;
                            end
                            2'd2: begin
                                // End of SCL high, sample before the fall
                                rdata_q <= {rdata_q[6:0], sda};
                                scl_oe  <= 1'b1;
                                if (bit_cnt == 3'd0) begin
                                    phase <= 2'd3;       // SDA stays released, NACK
                                end else begin
                                    bit_cnt <= bit_cnt - 1'b1;
                                    phase   <= 2'd0;
                                end
                            end
                            default: begin
                                scl_oe <= 1'b0;
                                phase  <= 2'd0;
                                state  <= i2c_pkg::STOP_COND;
                            end
                        endcase
                    end
                end

                i2c_pkg::STOP_COND: begin
                    if (tick) begin
                        if (phase == 2'd0) begin
                            scl_oe <= 1'b1;
                            sda_oe <= 1'b1;              // SDA low under SCL low
                            phase  <= 2'd1;
                        end else begin
                            scl_oe <= 1'b0;              // SDA rises one clock later
                            sda_oe <= 1'b0;
                            done   <= 1'b1;
                            phase  <= 2'd0;
                            state  <= i2c_pkg::IDLE;
                        end
                    end
                end

                default: state <= i2c_pkg::IDLE;
            endcase
        end
    end

    assign rsp = '{chan: i2c_pkg::chan_t'(chan_id), rw: rw_q, nack: nack_q, rdata: rdata_q};

endmodule

// ==== rtl/i2c_rsp_collect.sv ====
// ==========================================================
// Gathers done strobes from all masters
// One response per cycle, lowest channel first
// A channel must not finish again before its result drains
// ==========================================================
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_rsp_collect (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`I2C_NUM_CHAN-1:0] done,
    input  i2c_pkg::i2c_rsp_t        chan_rsp [`I2C_NUM_CHAN],
    output logic                     rsp_valid,
    output i2c_pkg::i2c_rsp_t        rsp
);

    logic [`I2C_NUM_CHAN-1:0] pending;
    logic [`I2C_NUM_CHAN-1:0] req;
    logic [`I2C_NUM_CHAN-1:0] grant;
    i2c_pkg::i2c_rsp_t        held [`I2C_NUM_CHAN];
    i2c_pkg::i2c_rsp_t        sel_rsp;

    assign req = pending | done;   // Fresh done bypasses the hold register

    // Lowest index wins, scan from the top
    always_comb begin
        grant   = '0;
        sel_rsp = '0;
        for (int i = `I2C_NUM_CHAN - 1; i >= 0; i--) begin
            if (req[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
                sel_rsp  = pending[i] ? held[i] : chan_rsp[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending   <= '0;
            rsp_valid <= 1'b0;
        end else begin
            pending   <= req & ~grant;
            rsp_valid <= |req;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `I2C_NUM_CHAN; i++) begin
            if (done[i]) begin
                held[i] <= chan_rsp[i];
            end
        end
        if (|req) begin
            rsp <= sel_rsp;
        end
    end

endmodule

// ==== rtl/i2c_multi_top.sv ====
// ==========================================================
// Multi-channel I2C controller, one master per bus
// SDA and SCL need external pull-ups
// ==========================================================
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_multi_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  i2c_pkg::i2c_cmd_t        cmd,
    output logic                     reject,
    output logic [`I2C_NUM_CHAN-1:0] busy,
    output logic                     rsp_valid,
    output i2c_pkg::i2c_rsp_t        rsp,
    inout  wire  [`I2C_NUM_CHAN-1:0] sda,
    inout  wire  [`I2C_NUM_CHAN-1:0] scl
);

    logic [`I2C_NUM_CHAN-1:0] start;
    logic [`I2C_NUM_CHAN-1:0] done;
    logic                     start_rw;
    logic [7:0]               start_wdata;
    i2c_pkg::i2c_rsp_t        chan_rsp [`I2C_NUM_CHAN];

    i2c_cmd_dispatch i_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .cmd         (cmd),
        .chan_busy   (busy),
        .start       (start),
        .start_rw    (start_rw),
        .start_wdata (start_wdata),
        .reject      (reject)
    );

    // One master per bus, all share the start data
    for (genvar g = 0; g < `I2C_NUM_CHAN; g++) begin : g_chan
        i2c_byte_master #(
            .chan_id (g)
        ) i_master (
            .clk         (clk),
            .rst_n       (rst_n),
            .start       (start[g]),
            .start_rw    (start_rw),
            .start_wdata (start_wdata),
            .busy        (busy[g]),
            .done        (done[g]),
            .rsp         (chan_rsp[g]),
            .sda         (sda[g]),
            .scl         (scl[g])
        );
    end

    i2c_rsp_collect i_collect (
        .clk       (clk),
        .rst_n     (rst_n),
        .done      (done),
        .chan_rsp  (chan_rsp),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

// ==== bench/i2c_slave_model.sv ====
// ==========================================================
// Behavioral I2C target for one bus, no clock stretching
// ACKs dev_addr, keeps the last written byte, returns read_byte
// One data byte per transfer, then waits for STOP
// ==========================================================
`timescale 1ns/10ps

module i2c_slave_model (
    inout  wire         sda,
    inout  wire         scl,
    input  logic [6:0]  dev_addr,
    input  logic [7:0]  read_byte,
    output logic [7:0]  last_wdata,
    output logic [15:0] wr_count
);

    typedef enum int {S_IDLE, S_ADDR, S_WRITE, S_READ, S_MACK} slave_mode_e;

    slave_mode_e mode;
    logic        sda_low;     // 1 = pull SDA low
    logic        scl_q;
    logic        sda_q;
    logic        rw_q;
    logic        ack_next;    // ACK on the coming SCL low phase
    logic        in_ack;
    logic [7:0]  shift;
    logic [7:0]  tx;
    int          bit_cnt;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial begin
        mode       = S_IDLE;
        sda_low    = 1'b0;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        rw_q       = 1'b0;
        ack_next   = 1'b0;
        in_ack     = 1'b0;
        shift      = 8'h00;
        tx         = 8'h00;
        bit_cnt    = 0;
        last_wdata = 8'h00;
        wr_count   = 16'd0;
    end

    // Next read bit onto SDA, MSB first
    task send_bit();
        sda_low = ~tx[7];
        tx      = {tx[6:0], 1'b0};
        bit_cnt = bit_cnt + 1;
    endtask

    task handle_rise();
        if (!in_ack) begin
            case (mode)
                S_ADDR: begin
                    shift   = {shift[6:0], sda};
                    bit_cnt = bit_cnt + 1;
                    if (bit_cnt == 8) begin
                        if (shift[7:1] == dev_addr) begin
                            rw_q     = shift[0];
                            ack_next = 1'b1;
                        end else begin
                            mode = S_IDLE;           // Not addressed
                        end
                    end
                end
                S_WRITE: begin
                    shift   = {shift[6:0], sda};
                    bit_cnt = bit_cnt + 1;
                    if (bit_cnt == 8) begin
                        last_wdata = shift;
                        wr_count   = wr_count + 1'b1;
                        ack_next   = 1'b1;
                    end
                end
                S_MACK: mode = S_IDLE;               // Master NACK ends the read
                default: ;
            endcase
        end
    endtask

    task handle_fall();
        if (ack_next) begin
            ack_next = 1'b0;
            in_ack   = 1'b1;
            sda_low  = 1'b1;
        end else if (in_ack) begin
            in_ack  = 1'b0;
            sda_low = 1'b0;
            bit_cnt = 0;
            if (mode == S_ADDR && rw_q) begin
                mode = S_READ;
                tx   = read_byte;
                send_bit();
            end else if (mode == S_ADDR) begin
                mode = S_WRITE;
            end else begin
                mode = S_IDLE;                       // Byte done, wait for STOP
            end
        end else if (mode == S_READ) begin
            if (bit_cnt == 8) begin
                sda_low = 1'b0;                      // Leave SDA to the master
                mode    = S_MACK;
            end else begin
                send_bit();
            end
        end
    endtask

    // ======================================================
    // Bus conditions and SCL edges
    // ======================================================
    always @(scl or sda) begin
        if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            mode     = S_ADDR;                       // START
            bit_cnt  = 0;
            ack_next = 1'b0;
            in_ack   = 1'b0;
            sda_low  = 1'b0;
        end else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            mode     = S_IDLE;                       // STOP
            ack_next = 1'b0;
            in_ack   = 1'b0;
            sda_low  = 1'b0;
        end else if (scl === 1'b1 && scl_q !== 1'b1) begin
            handle_rise();
        end else if (scl === 1'b0 && scl_q === 1'b1) begin
            handle_fall();
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

// ==== bench/i2c_multi_props.sv ====
// ==========================================================
// Protocol checks bound into the multi-channel top level
// SCL is expected high on idle buses, so pull-ups are needed
// ==========================================================
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_multi_props (
    input logic                     clk,
    input logic                     rst_n,
    input logic [`I2C_NUM_CHAN-1:0] start,
    input logic [`I2C_NUM_CHAN-1:0] busy,
    input logic [`I2C_NUM_CHAN-1:0] done,
    input logic                     rsp_valid,
    input logic [`I2C_NUM_CHAN-1:0] scl
);

    logic [7:0] owed;   // Finished results not yet delivered

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owed <= 8'd0;
        end else begin
            owed <= owed + 8'($countones(done)) - 8'(rsp_valid);
        end
    end

    a_start_onehot_idle : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(start) && ((start & busy) == '0))
        else $error("start is not one-hot or targets a busy channel");

    a_rsp_after_done : assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (owed != 8'd0))
        else $error("rsp_valid without a finished transaction");

    // Idle bus keeps SCL released
    a_scl_idle : assert property (@(posedge clk) disable iff (!rst_n)
        ((scl | busy) == '1))
        else $error("SCL pulled low on an idle channel");

endmodule

// ==== bench/i2c_multi_tb.sv ====
// ==========================================================
// Testbench for the multi-channel I2C controller
// Needs at least two channels, one target model per bus
// Stops at the first error
// ==========================================================
`timescale 1ns/10ps
`include "i2c_cfg.svh"

module i2c_multi_tb;

    localparam int n_chan     = `I2C_NUM_CHAN;
    // One transaction is 54 quarter ticks, budget for 24 of them
    localparam int txn_cycles = 54 * `I2C_QUARTER_DIV;
    localparam int max_cycles = 24 * txn_cycles + 560;

    logic              clk;
    logic              rst_n;
    logic              load;
    i2c_pkg::i2c_cmd_t cmd;
    logic              reject;
    logic [n_chan-1:0] busy;
    logic              rsp_valid;
    i2c_pkg::i2c_rsp_t rsp;
    wire  [n_chan-1:0] sda;
    wire  [n_chan-1:0] scl;

    logic [6:0]        slave_addr [n_chan];
    logic [7:0]        slave_rd [n_chan];
    logic [7:0]        slave_wdata [n_chan];
    logic [15:0]       slave_wr_cnt [n_chan];

    i2c_pkg::i2c_rsp_t exp_q [$];     // Outstanding expected responses
    string             test_name;
    int                cycle_cnt = 0;

    i2c_multi_top i_i2c_multi_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .cmd       (cmd),
        .reject    (reject),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .sda       (sda),
        .scl       (scl)
    );

    for (genvar g = 0; g < n_chan; g++) begin : g_bus
        pullup (sda[g]);
        pullup (scl[g]);

        i2c_slave_model i_slave (
            .sda        (sda[g]),
            .scl        (scl[g]),
            .dev_addr   (slave_addr[g]),
            .read_byte  (slave_rd[g]),
            .last_wdata (slave_wdata[g]),
            .wr_count   (slave_wr_cnt[g])
        );
    end

    bind i2c_multi_top i2c_multi_props i_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .rsp_valid (rsp_valid),
        .scl       (scl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ======================================================
    // Failure reporting and checks
    // ======================================================
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch in %s (%s): expected 0x%0h, actual 0x%0h",
                               test_name, what, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            fail_run($sformatf("Run did not finish within %0d cycles", max_cycles));
        end
    end

    // Expected response from the command and the target setup
    function automatic i2c_pkg::i2c_rsp_t expected_rsp(input i2c_pkg::i2c_cmd_t c,
                                                       input logic [7:0]        rd_byte,
                                                       input logic [6:0]        addr);
        i2c_pkg::i2c_rsp_t r;
        logic              acked;
        acked   = (addr == `I2C_DEV_ADDR);
        r.chan  = c.chan;
        r.rw    = c.rw;
        r.nack  = !acked;
        r.rdata = (acked && c.rw) ? rd_byte : 8'h00;   // Writes and NACKs give zero
        return r;
    endfunction

    // Scoreboard, DUT outputs sampled on the falling edge
    always @(negedge clk) begin
        int idx;
        idx = -1;
        if (rst_n && rsp_valid) begin
            for (int i = exp_q.size() - 1; i >= 0; i--) begin
                if (exp_q[i].chan == rsp.chan) begin
                    idx = i;                          // Oldest entry of this channel
                end
            end
            if (idx < 0) begin
                fail_run($sformatf("Response on channel %0d with no command outstanding",
                                   rsp.chan));
            end else begin
                check_value("response", exp_q[idx], rsp);
                exp_q.delete(idx);
            end
        end
    end

    // ======================================================
    // Stimulus helpers, called on a falling edge
    // ======================================================
    task automatic issue_cmd(input int chan, input logic rw, input logic [7:0] wdata,
                             input logic exp_reject);
        i2c_pkg::i2c_cmd_t c;
        c.chan  = i2c_pkg::chan_t'(chan);
        c.rw    = rw;
        c.wdata = wdata;
        load    = 1'b1;
        cmd     = c;
        @(negedge clk);
        load = 1'b0;
        check_value("reject", exp_reject, reject);
        if (!exp_reject) begin
            exp_q.push_back(expected_rsp(c, slave_rd[chan], slave_addr[chan]));
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    function automatic logic [7:0] rand_byte();
        return 8'($urandom());
    endfunction

    // ======================================================
    // Test sequence
    // ======================================================
    initial begin
        logic [7:0]  wdata;
        logic [15:0] cnt_before;
        void'($urandom(48));
        rst_n     = 1'b0;
        load      = 1'b0;
        cmd       = '0;
        test_name = "reset";
        for (int i = 0; i < n_chan; i++) begin
            slave_addr[i] = `I2C_DEV_ADDR;
            slave_rd[i]   = 8'h00;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("reject", 0, reject);
        check_value("rsp_valid", 0, rsp_valid);
        check_value("sda pins", {n_chan{1'b1}}, sda);
        check_value("scl pins", {n_chan{1'b1}}, scl);

        test_name = "write";
        for (int c = 0; c < n_chan; c++) begin
            wdata      = rand_byte();
            cnt_before = slave_wr_cnt[c];
            issue_cmd(c, 1'b0, wdata, 1'b0);
            @(negedge clk);
            check_value("busy rise", 1'b1, busy[c]);
            wait_drain();
            check_value("target byte", wdata, slave_wdata[c]);
            check_value("target write count", cnt_before + 16'd1, slave_wr_cnt[c]);
        end

        test_name = "read";
        for (int c = 0; c < n_chan; c++) begin
            slave_rd[c] = rand_byte();
            issue_cmd(c, 1'b1, rand_byte(), 1'b0);
            wait_drain();
        end

        test_name = "busy reject";
        cnt_before = slave_wr_cnt[0];
        issue_cmd(0, 1'b0, rand_byte(), 1'b0);
        issue_cmd(0, 1'b1, 8'h00, 1'b1);              // Start still in flight
        @(negedge clk);
        issue_cmd(0, 1'b0, rand_byte(), 1'b1);        // Master busy
        if ((1 << i2c_pkg::chan_w) > n_chan) begin
            issue_cmd(n_chan, 1'b0, 8'h00, 1'b1);     // Out of range
        end
        wait_drain();
        repeat (4) @(negedge clk);
        check_value("busy", 0, busy);
        check_value("target write count", cnt_before + 16'd1, slave_wr_cnt[0]);

        test_name = "concurrent";
        wdata       = rand_byte();
        slave_rd[1] = rand_byte();
        issue_cmd(0, 1'b0, wdata, 1'b0);
        issue_cmd(1, 1'b1, rand_byte(), 1'b0);
        wait_drain();
        check_value("target byte", wdata, slave_wdata[0]);

        test_name     = "wrong address";
        slave_addr[1] = `I2C_DEV_ADDR ^ 7'h05;
        slave_rd[1]   = rand_byte();
        cnt_before    = slave_wr_cnt[1];
        issue_cmd(1, 1'b1, 8'h00, 1'b0);
        wait_drain();
        check_value("busy after nack", 1'b0, busy[1]);
        issue_cmd(1, 1'b0, rand_byte(), 1'b0);
        wait_drain();
        check_value("busy after nack", 1'b0, busy[1]);
        check_value("target write count", cnt_before, slave_wr_cnt[1]);
        slave_addr[1] = `I2C_DEV_ADDR;

        // Window for a stray response to reach the scoreboard
        repeat (5) @(negedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/i2c_pkg.sv
rtl/i2c_cmd_dispatch.sv
rtl/i2c_byte_master.sv
rtl/i2c_rsp_collect.sv
rtl/i2c_multi_top.sv
bench/i2c_slave_model.sv
bench/i2c_multi_props.sv
bench/i2c_multi_tb.sv
